// File: div_pkg.sv
// divide unit shared types
// operand and result widths, function select and lane state encoding

package div_pkg;

  // --------------------------------------------------
  // data widths
  // --------------------------------------------------

  // dividend or divisor
  typedef logic [31:0] operand_t;

  // remainder in [63:32], quotient in [31:0]
  typedef logic [63:0] result_t;

  // --------------------------------------------------
  // function select
  // --------------------------------------------------

  // fn value for signed division, fn 0 is unsigned
  localparam logic DIV_FN_SIGNED = 1'b1;

  // --------------------------------------------------
  // lane control states
  // --------------------------------------------------

  // IDLE waits for a request
  // CALC runs the 32 shift-subtract steps
  // DONE holds the result until it is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } lane_state_e;

endpackage

// File: div_req_if.sv
// divide request bundle
// valid/ready handshake with function select and both operands

`timescale 1ns/1ns

interface div_req_if;
  import div_pkg::*;

  logic     req_val;
  logic     req_rdy;
  // 0 unsigned, 1 signed
  logic     fn;
  operand_t a;
  operand_t b;

  // side that issues requests
  modport sender (output req_val, fn, a, b, input req_rdy);

  // side that accepts requests
  modport receiver (input req_val, fn, a, b, output req_rdy);

endinterface

// File: div_lane_dpath.sv
// lane datapath for restoring division
// operand magnitudes, 32 shift-subtract steps, then sign and zero-divisor fixup

`timescale 1ns/1ns

module div_lane_dpath (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              step,
  input  logic              fn,
  input  div_pkg::operand_t a,
  input  div_pkg::operand_t b,
  output logic              last_step,
  output div_pkg::result_t  result
);
  import div_pkg::*;

  // remainder in [64:32], quotient bits shift in at [0]
  logic [64:0] rq;
  operand_t    divisor;
  // kept for the divide-by-zero remainder
  operand_t    dividend;
  logic [4:0]  count;
  logic        quo_neg;
  logic        rem_neg;
  logic        div_zero;

  logic        is_signed;
  operand_t    a_mag;
  operand_t    b_mag;
  logic [64:0] rq_shift;
  logic [64:0] diff;
  logic [64:0] rq_next;
  operand_t    quo_raw;
  operand_t    rem_raw;
  operand_t    quo_fix;
  operand_t    rem_fix;

  // --------------------------------------------------
  // operand conditioning
  // --------------------------------------------------

  assign is_signed = (fn == DIV_FN_SIGNED);

  // magnitudes, unsigned operands pass straight through
  assign a_mag = (is_signed && a[31]) ? (~a + 32'd1) : a;
  assign b_mag = (is_signed && b[31]) ? (~b + 32'd1) : b;

  // --------------------------------------------------
  // shift-subtract step
  // --------------------------------------------------

  assign rq_shift = {rq[63:0], 1'b0};
  assign diff     = rq_shift - {1'b0, divisor, 32'b0};

  // negative difference restores the shifted value with a 0 quotient bit
  assign rq_next = diff[64] ? rq_shift : {diff[64:1], 1'b1};

  // control side registers
  always_ff @(posedge clk) begin
    if (reset) begin
      count    <= '0;
      quo_neg  <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      count    <= 5'd31;
      // quotient sign from both operands, remainder follows the dividend
      quo_neg  <= is_signed && (a[31] ^ b[31]);
      rem_neg  <= is_signed && a[31];
      div_zero <= (b == '0);
    end else if (step) begin
      count <= count - 5'd1;
    end
  end

  // operand and partial result registers
  always_ff @(posedge clk) begin
    if (load) begin
      rq       <= {33'b0, a_mag};
      divisor  <= b_mag;
      dividend <= a;
    end else if (step) begin
      rq <= rq_next;
    end
  end

  assign last_step = (count == 5'd0);

  // --------------------------------------------------
  // result fixup
  // --------------------------------------------------

  assign quo_raw = rq[31:0];
  assign rem_raw = rq[63:32];

  assign quo_fix = quo_neg ? (~quo_raw + 32'd1) : quo_raw;
  assign rem_fix = rem_neg ? (~rem_raw + 32'd1) : rem_raw;

  // divide by zero: all-ones quotient, dividend as remainder, either fn
  assign result = div_zero ? {dividend, 32'hffff_ffff} : {rem_fix, quo_fix};

endmodule

// File: div_lane.sv
// one divider lane
// control FSM around the restoring shift-subtract datapath

`timescale 1ns/1ns

module div_lane (
  input  logic             clk,
  input  logic             reset,
  div_req_if.receiver      req,
  output logic             resp_val,
  input  logic             resp_rdy,
  output div_pkg::result_t result
);
  import div_pkg::*;

  lane_state_e state;
  lane_state_e state_next;

  // datapath controls and status
  logic load;
  logic step;
  logic last_step;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  div_lane_dpath dpath_i (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .fn        (req.fn),
    .a         (req.a),
    .b         (req.b),
    .last_step (last_step),
    .result    (result)
  );

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // request accepted, start iterating next cycle
        if (req.req_val) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // the 32nd step happens on this edge
        if (last_step) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // hold until the collector takes the result
        if (resp_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // only an idle lane takes a new request
  assign req.req_rdy = (state == IDLE);

  // capture operands on the accepting edge
  assign load = req.req_val && req.req_rdy;

  // one shift-subtract per CALC cycle
  assign step = (state == CALC);

  assign resp_val = (state == DONE);

  // a stalled response must stay put until it is taken
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(result))
    else $error("lane result changed while the response was stalled");

endmodule

// File: div_dispatch.sv
// request dispatcher
// hands each accepted request to the next lane in round-robin order

`timescale 1ns/1ns

module div_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic        clk,
  input  logic        reset,
  div_req_if.receiver in,
  div_req_if.sender   lanes [NUM_LANES]
);

  localparam int IDX_W = $clog2(NUM_LANES);
  localparam logic [IDX_W-1:0] LAST_LANE = IDX_W'(NUM_LANES - 1);

  // lane whose turn it is to take the next request
  logic [IDX_W-1:0]     turn;
  logic [NUM_LANES-1:0] lane_val;
  logic [NUM_LANES-1:0] lane_rdy;
  logic                 xfer;

  // --------------------------------------------------
  // fan out to lanes
  // --------------------------------------------------

  // payload goes to every lane, valid only to the lane in turn
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_val[g]      = in.req_val && (turn == IDX_W'(g));
    assign lanes[g].req_val = lane_val[g];
    assign lanes[g].fn      = in.fn;
    assign lanes[g].a       = in.a;
    assign lanes[g].b       = in.b;
    assign lane_rdy[g]      = lanes[g].req_rdy;
  end

  // upstream sees ready from the lane in turn only
  assign in.req_rdy = lane_rdy[turn];
  assign xfer       = in.req_val && in.req_rdy;

  // --------------------------------------------------
  // turn pointer
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      turn <= '0;
    end else if (xfer) begin
      // wrap after the last lane
      if (turn == LAST_LANE) begin
        turn <= '0;
      end else begin
        turn <= turn + 1'b1;
      end
    end
  end

  // a request must never be offered to two lanes at once
  a_one_lane_val: assert property (@(posedge clk) disable iff (reset)
    $onehot0(lane_val))
    else $error("request valid raised on more than one lane");

endmodule

// File: div_collect.sv
// response collector
// drains lane results in round-robin order so responses keep request order

`timescale 1ns/1ns

module div_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [NUM_LANES-1:0] lane_resp_val,
  output logic [NUM_LANES-1:0] lane_resp_rdy,
  input  div_pkg::result_t     lane_result [NUM_LANES],
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output div_pkg::result_t     result
);

  localparam int IDX_W = $clog2(NUM_LANES);
  localparam logic [IDX_W-1:0] LAST_LANE = IDX_W'(NUM_LANES - 1);

  // lane that owns the next response in order
  logic [IDX_W-1:0] ptr;
  logic             xfer;

  // --------------------------------------------------
  // output select
  // --------------------------------------------------

  // other lanes may be done already but wait their turn
  assign resp_val = lane_resp_val[ptr];
  assign result   = lane_result[ptr];

  // ready goes back to the pointed lane alone
  always_comb begin
    lane_resp_rdy      = '0;
    lane_resp_rdy[ptr] = resp_rdy;
  end

  assign xfer = resp_val && resp_rdy;

  // --------------------------------------------------
  // drain pointer
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (xfer) begin
      if (ptr == LAST_LANE) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

endmodule

// File: div_array.sv
// multi-lane iterative divide unit
// dispatcher, NUM_LANES divider lanes and an in-order collector

`timescale 1ns/1ns

module div_array #(
  parameter int NUM_LANES = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  logic              fn,
  input  div_pkg::operand_t a,
  input  div_pkg::operand_t b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output div_pkg::result_t  result
);
  import div_pkg::*;

  // incoming request and one request bundle per lane
  div_req_if req_in ();
  div_req_if lane_req [NUM_LANES] ();

  // per-lane response side
  logic [NUM_LANES-1:0] lane_resp_val;
  logic [NUM_LANES-1:0] lane_resp_rdy;
  result_t              lane_result [NUM_LANES];

  // round-robin needs at least two lanes
  if (NUM_LANES < 2) begin : g_bad_lanes
    $error("div_array needs NUM_LANES of 2 or more");
  end

  // --------------------------------------------------
  // request side
  // --------------------------------------------------

  assign req_in.req_val = req_val;
  assign req_in.fn      = fn;
  assign req_in.a       = a;
  assign req_in.b       = b;
  assign req_rdy        = req_in.req_rdy;

  div_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) dispatch_i (
    .clk   (clk),
    .reset (reset),
    .in    (req_in),
    .lanes (lane_req)
  );

  // --------------------------------------------------
  // lanes
  // --------------------------------------------------

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    div_lane lane_i (
      .clk      (clk),
      .reset    (reset),
      .req      (lane_req[g]),
      .resp_val (lane_resp_val[g]),
      .resp_rdy (lane_resp_rdy[g]),
      .result   (lane_result[g])
    );
  end

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  div_collect #(
    .NUM_LANES (NUM_LANES)
  ) collect_i (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_val (lane_resp_val),
    .lane_resp_rdy (lane_resp_rdy),
    .lane_result   (lane_result),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .result        (result)
  );

endmodule

// File: tb_div_array.sv
// testbench for the multi-lane divide unit
// table-driven requests, in-order response checks, random response stalls

`timescale 1ns/1ns

module tb_div_array;
  import div_pkg::*;

  localparam int NUM_LANES = 4;
  localparam int NUM_VEC   = 16;
  // pass 0 keeps resp_rdy high, pass 1 stalls it at random
  localparam int NUM_PASS  = 2;
  localparam int TIMEOUT   = 2000;

  typedef struct packed {
    logic     fn;
    operand_t a;
    operand_t b;
    result_t  expected;
  } vec_t;

  logic     clk;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  logic     fn;
  operand_t a;
  operand_t b;
  logic     resp_val;
  logic     resp_rdy;
  result_t  result;

  integer value_errors;
  integer timeout_errors;
  integer seed;
  bit     aborted;

  // --------------------------------------------------
  // vector table: fn, a, b, {remainder, quotient}
  // --------------------------------------------------

  vec_t vecs [NUM_VEC] = '{
    // unsigned
    '{1'b0, 32'd100,        32'd7,        64'h00000002_0000000e},
    '{1'b0, 32'd5,          32'd9,        64'h00000005_00000000},
    '{1'b0, 32'hdeadbeef,   32'd1,        64'h00000000_deadbeef},
    '{1'b0, 32'hffffffff,   32'h10,       64'h0000000f_0fffffff},
    '{1'b0, 32'h80000000,   32'hffffffff, 64'h80000000_00000000},
    '{1'b0, 32'd1000000,    32'd1000,     64'h00000000_000003e8},
    // signed, every sign combination, rounding toward zero
    '{1'b1, 32'd7,          32'd2,        64'h00000001_00000003},
    '{1'b1, 32'hfffffff9,   32'd2,        64'hffffffff_fffffffd},
    '{1'b1, 32'd7,          32'hfffffffe, 64'h00000001_fffffffd},
    '{1'b1, 32'hfffffff9,   32'hfffffffe, 64'hffffffff_00000003},
    '{1'b1, 32'hffffff9c,   32'd7,        64'hfffffffe_fffffff2},
    '{1'b1, 32'hffffffff,   32'd1,        64'h00000000_ffffffff},
    '{1'b1, 32'h7fffffff,   32'hffffffff, 64'h00000000_80000001},
    // divide by zero under both fn values
    '{1'b0, 32'h12345678,   32'd0,        64'h12345678_ffffffff},
    '{1'b1, 32'hfffffff9,   32'd0,        64'hfffffff9_ffffffff},
    // signed overflow
    '{1'b1, 32'h80000000,   32'hffffffff, 64'h00000000_80000000}
  };

  div_array #(
    .NUM_LANES (NUM_LANES)
  ) dut_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .fn       (fn),
    .a        (a),
    .b        (b),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  // offer one request and hold it until the transfer edge has passed
  task automatic send_request(input vec_t v, input int idx);
    int waits;
    waits = 0;
    req_val = 1'b1;
    fn      = v.fn;
    a       = v.a;
    b       = v.b;
    // req_rdy follows DUT state only, settled 2 ns after the edge
    while (!req_rdy && waits < TIMEOUT && !aborted) begin
      @(posedge clk);
      #2;
      waits++;
    end
    if (!req_rdy) begin
      $display("timeout: request %0d was never accepted", idx);
      timeout_errors++;
      aborted = 1'b1;
    end else begin
      @(posedge clk);
      #2;
    end
  endtask

  // back-to-back requests, the whole table once per pass
  task automatic send_all();
    for (int p = 0; p < NUM_PASS && !aborted; p++) begin
      for (int i = 0; i < NUM_VEC && !aborted; i++) begin
        send_request(vecs[i], p * NUM_VEC + i);
      end
    end
    req_val = 1'b0;
  endtask

  // drive resp_rdy each cycle until a transfer is due on the next edge
  task automatic wait_response(input int n);
    int waits;
    waits = 0;
    forever begin
      if (n < NUM_VEC) begin
        resp_rdy = 1'b1;
      end else begin
        resp_rdy = 1'($random(seed));
      end
      if (resp_val && resp_rdy) begin
        break;
      end
      if (waits >= TIMEOUT || aborted) begin
        $display("timeout: response %0d never arrived", n);
        timeout_errors++;
        aborted = 1'b1;
        break;
      end
      @(posedge clk);
      #2;
      waits++;
    end
  endtask

  // responses must come back in request order
  task automatic receive_all();
    string name;
    for (int n = 0; n < NUM_PASS * NUM_VEC && !aborted; n++) begin
      wait_response(n);
      if (!aborted) begin
        name = $sformatf("pass %0d vec %0d", n / NUM_VEC, n % NUM_VEC);
        check_value(name, vecs[n % NUM_VEC].expected, result);
        @(posedge clk);
        #2;
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    value_errors   = 0;
    timeout_errors = 0;
    aborted        = 1'b0;
    seed           = 32'h71c3ec19;
    reset    = 1'b1;
    req_val  = 1'b0;
    fn       = 1'b0;
    a        = '0;
    b        = '0;
    resp_rdy = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    // idle outputs before any request
    check_value("reset resp_val", 64'd0, {63'd0, resp_val});
    check_value("reset req_rdy", 64'd1, {63'd0, req_rdy});

    fork
      send_all();
      receive_all();
    join

    // no extra or duplicated result once everything is drained
    resp_rdy = 1'b1;
    repeat (40) begin
      @(posedge clk);
      #2;
      check_value("quiet after drain", 64'd0, {63'd0, resp_val});
    end

    $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: src.f
div_pkg.sv
div_req_if.sv
div_lane_dpath.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_array.sv
tb_div_array.sv

// File: Makefile
# Verilator flow for the multi-lane divide unit

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP_TB    ?= tb_div_array
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP_TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
